//--- Makefile
# Verilator build and run of the ROM bridge testbench
SIM  := obj_dir/VromBridgeTb
SRCS := $(filter-out +%,$(shell cat romBridge.f)) logic/romBridge_params.svh

.PHONY: all run clean

all: run

$(SIM): romBridge.f $(SRCS)
	verilator --binary --timing --assert --top-module romBridgeTb -f romBridge.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

//--- dv/romBridgeTb.sv
// Self-checking testbench of the ROM bridge top that drives the APB and SPI pins and asserts on responses
`timescale 1ns/1ps
`default_nettype none
`include "romBridge_params.svh"

module romBridgeTb;
	import romBridgePkg::*;

	localparam int HbTestPeriod = 5;            // Short LED period for the heartbeat test

	wire                    iSCLK;
	wire                    iPllLocked;
	logic                   iPsel;
	logic                   iPenable;
	logic                   iPwrite;
	logic [`APB_ADDR_W-1:0] iPaddr;
	logic [`APB_DATA_W-1:0] iPwdata;
	wire  [`APB_DATA_W-1:0] oPrdata;
	wire                    oPready;
	wire                    oPslverr;
	logic                   iMaster_MOSI;
	logic                   iMaster_SCK;
	logic [3:0]             iMaster_nCS;
	wire                    oMaster_MISO;
	logic [3:0]             iUser_MISO;
	wire  [3:0]             oUser_MOSI;
	wire  [3:0]             oUser_SCK;
	wire  [3:0]             oUser_nCS;
	wire  [3:0]             oUserDebug;
	wire  [2:0]             oLed;
	// Reference model
	logic [15:0]            lfsrState = 16'd36;
	logic [3:0]             tbMask = 4'hF;       // Mirror of CTRL
	int                     romModel [4] = '{0, 0, 0, 0};
	int                     errModel = 0;
	int                     lastRom = 0;         // Last clean one-hot selection
	logic [2:0]             ledModel = 3'd0;

	tbClock clock_i (.sclk(iSCLK), .pllLocked(iPllLocked));

	romBridgeTop dut_i (
		.iSCLK(iSCLK), .iPllLocked(iPllLocked),
		.iPsel(iPsel), .iPenable(iPenable), .iPwrite(iPwrite), .iPaddr(iPaddr),
		.iPwdata(iPwdata), .oPrdata(oPrdata), .oPready(oPready), .oPslverr(oPslverr),
		.iMaster_MOSI(iMaster_MOSI), .iMaster_SCK(iMaster_SCK), .iMaster_nCS(iMaster_nCS),
		.oMaster_MISO(oMaster_MISO), .iUser_MISO(iUser_MISO), .oUser_MOSI(oUser_MOSI),
		.oUser_SCK(oUser_SCK), .oUser_nCS(oUser_nCS), .oUserDebug(oUserDebug), .oLed(oLed)
	);

	// --------------------------------------------------
	// Failure reporting and random bits
	// --------------------------------------------------
	task automatic failRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		failRun($sformatf("CHECK FAILED at %0t: %s expected 0x%0h, actual 0x%0h",
			$time, name, exp, act));
	endtask

	task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
			mismatch(name, exp, act);
	endtask

	// Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1 and one step per bit
	function automatic logic [7:0] randBits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
			v = {v[6:0], lfsrState[0]};
		end
		return v;
	endfunction

	// --------------------------------------------------
	// APB master
	// --------------------------------------------------
	task automatic apbAccess(input logic isWrite, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waitCycles;
		@(negedge iSCLK);
		iPsel    = 1'b1;                        // Setup phase
		iPenable = 1'b0;
		iPwrite  = isWrite;
		iPaddr   = addr;
		iPwdata  = wdata;
		@(negedge iSCLK);
		iPenable   = 1'b1;                      // Access phase
		waitCycles = 0;
		do
		begin
			@(negedge iSCLK);
			waitCycles++;
			if (waitCycles > 8)
				failRun("APB access saw no oPready within 8 clocks");
		end
		while (!oPready);
		rdata    = oPrdata;                     // Still the access-phase values
		err      = oPslverr;
		iPsel    = 1'b0;
		iPenable = 1'b0;
		iPwrite  = 1'b0;
	endtask

	task automatic readExpect(input string name, input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] rdata;
		logic        err;
		apbAccess(1'b0, addr, '0, rdata, err);
		checkEq({name, " pslverr"}, 32'd0, 32'(err));
		checkEq(name, exp, rdata);
	endtask

	// --------------------------------------------------
	// SPI frame of four SCK toggles with random MOSI and ROM MISO
	// --------------------------------------------------
	task automatic spiFrame(input logic [3:0] ncs);
		logic [3:0] gated;
		int         expRom;
		logic       expMiso;
		logic [3:0] dbgExp;
		gated  = ncs | ~tbMask;                 // Disabled ROMs never see a select
		expRom = -1;
		for (int k = 0; k < 4; k++)
			if (!gated[k] && $countones(gated) == 3)
				expRom = k;
		if (expRom >= 0)
			lastRom = expRom;
		@(negedge iSCLK);
		iMaster_nCS = ncs;
		iUser_MISO  = 4'(randBits(4));
		for (int b = 0; b < 5; b++)
		begin
			@(negedge iSCLK);
			// Select registered at the last rising edge and MISO from the previous draw
			expMiso = (expRom >= 0) ? iUser_MISO[expRom] : 1'b0;
			checkEq("oMaster_MISO", 32'(expMiso), 32'(oMaster_MISO));
			// Debug pins hold the master lines from that edge with MISO still idle on the first bit
			dbgExp = {&ncs, iMaster_SCK, iMaster_MOSI, (b == 0) ? 1'b0 : expMiso};
			checkEq("oUserDebug", 32'(dbgExp), 32'(oUserDebug));
			if (b < 4)
			begin
				iMaster_SCK  = ~iMaster_SCK;
				iMaster_MOSI = 1'(randBits(1));
				iUser_MISO   = 4'(randBits(4));
			end
		end
		iMaster_nCS  = 4'hF;
		iMaster_MOSI = 1'b0;
		repeat (3) @(negedge iSCLK);            // Idle gap lets the counters settle 2 clocks after the edge
		// All selects high again
		checkEq("oUserDebug idle", 32'({1'b1, iMaster_SCK, 2'b00}), 32'(oUserDebug));
	endtask

	// --------------------------------------------------
	// Cycle checks for the whole run
	// --------------------------------------------------
	assert property (@(posedge iSCLK) disable iff (!iPllLocked)
		oUser_SCK == {4{iMaster_SCK}} && oUser_MOSI == {4{iMaster_MOSI}})
	else
		mismatch("oUser_SCK/oUser_MOSI", 32'({{4{iMaster_SCK}}, {4{iMaster_MOSI}}}),
			32'({oUser_SCK, oUser_MOSI}));

	assert property (@(posedge iSCLK) disable iff (!iPllLocked)
		oUser_nCS == (iMaster_nCS | ~tbMask))
	else
		mismatch("oUser_nCS", 32'(iMaster_nCS | ~tbMask), 32'(oUser_nCS));

	// Zero wait states and no error outside access
	assert property (@(posedge iSCLK) disable iff (!iPllLocked)
		oPready == (iPsel && iPenable) && (oPready || !oPslverr))
	else
		mismatch("oPready/oPslverr", 32'({iPsel && iPenable, 1'b0}), 32'({oPready, oPslverr}));

	initial
	begin
		logic [31:0] rdata;
		logic        err;
		int          frames;
		int          gap;
		iPsel        = 1'b0;
		iPenable     = 1'b0;
		iPwrite      = 1'b0;
		iPaddr       = '0;
		iPwdata      = '0;
		iMaster_MOSI = 1'b0;
		iMaster_SCK  = 1'b0;
		iMaster_nCS  = 4'hF;
		iUser_MISO   = 4'h0;
		gap          = 0;
		while (!iPllLocked)
		begin
			@(negedge iSCLK);
			gap++;
			if (gap > 20)
				failRun("Reset was not released within 20 clocks");
		end

		// Reset values
		readExpect("CTRL", CTRL, 32'hF);
		readExpect("HBPERIOD", HBPERIOD, 32'(`HB_PERIOD_DEFAULT));
		readExpect("ERRCNT", ERRCNT, 32'd0);
		for (int k = 0; k < 4; k++)
			readExpect($sformatf("ROMCNT%0d", k), 8'h10 + 8'(4 * k), 32'd0);
		checkEq("oLed", 32'd0, 32'(oLed));

		// Routing and counting with all ROMs enabled
		for (int k = 0; k < 4; k++)
		begin
			frames = 32'(randBits(2)) + 1;
			repeat (frames) spiFrame(~(4'b0001 << k));
			romModel[k] += frames;
			apbAccess(1'b0, STATUS, '0, rdata, err);
			checkEq("STATUS selection", 32'({2'(k), 1'b1}), 32'(rdata[2:0]));
		end
		for (int k = 0; k < 4; k++)
			readExpect($sformatf("ROMCNT%0d", k), 8'h10 + 8'(4 * k), 32'(romModel[k]));

		// Two frames to disabled ROM 2 and one two-hot frame
		apbAccess(1'b1, CTRL, 32'hB, rdata, err);
		checkEq("CTRL write pslverr", 32'd0, 32'(err));
		tbMask = 4'hB;
		repeat (2) spiFrame(4'b1011);
		spiFrame(4'b1100);
		errModel += 3;
		readExpect("ERRCNT", ERRCNT, 32'(errModel));
		readExpect("ROMCNT2", ROMCNT2, 32'(romModel[2]));

		// APB errors leave the map untouched
		apbAccess(1'b0, 8'h24, '0, rdata, err);
		checkEq("unmapped read pslverr", 32'd1, 32'(err));
		checkEq("unmapped read prdata", 32'd0, rdata);
		apbAccess(1'b1, STATUS, 32'hFF, rdata, err);
		checkEq("STATUS write pslverr", 32'd1, 32'(err));
		checkEq("STATUS write prdata", 32'd0, rdata);
		readExpect("CTRL", CTRL, 32'hB);
		readExpect("HBPERIOD", HBPERIOD, 32'(`HB_PERIOD_DEFAULT));
		readExpect("ERRCNT", ERRCNT, 32'(errModel));
		readExpect("STATUS", STATUS, 32'({4'b0000, 2'(lastRom), 1'b1}));

		// Heartbeat with a short period
		apbAccess(1'b1, HBPERIOD, 32'(HbTestPeriod), rdata, err);
		checkEq("HBPERIOD write pslverr", 32'd0, 32'(err));
		for (int step = 0; step < 4; step++)
		begin
			gap = 0;
			while (oLed == ledModel)
			begin
				@(negedge iSCLK);
				gap++;
				if (gap > 8 * (HbTestPeriod + 1))
					failRun("oLed did not step within 8 heartbeat periods");
			end
			ledModel = ledModel + 3'd1;
			checkEq("oLed", 32'(ledModel), 32'(oLed));
			if (step > 0)
				checkEq("oLed step spacing", 32'(HbTestPeriod + 1), 32'(gap));
		end
		apbAccess(1'b0, STATUS, '0, rdata, err);    // Lands well before the next step
		checkEq("STATUS led", 32'(ledModel), 32'(rdata[6:4]));

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/tbClock.sv
// Testbench clock and power-on reset source, instanced once by the ROM bridge testbench
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic sclk,
	output logic pllLocked
);

	// 8 ns period
	initial
	begin
		sclk = 1'b0;
		forever #4 sclk = ~sclk;
	end

	// PLL lock, held low for 8 cycles, released away from the rising edge
	initial
	begin
		pllLocked = 1'b0;
		repeat (8) @(posedge sclk);
		@(negedge sclk);
		pllLocked = 1'b1;
	end

endmodule

`default_nettype wire

//--- logic/apbRegs.sv
// APB slave with the bridge control registers and the read-only router and LED status
`timescale 1ns/1ps
`default_nettype none
`include "romBridge_params.svh"

module apbRegs (
	input  wire                      iSCLK,
	input  wire                      iPllLocked,
	// APB
	input  wire                      iPsel,
	input  wire                      iPenable,
	input  wire                      iPwrite,
	input  wire [`APB_ADDR_W-1:0]    iPaddr,
	input  wire [`APB_DATA_W-1:0]    iPwdata,
	output logic [`APB_DATA_W-1:0]   oPrdata,
	output logic                     oPready,
	output logic                     oPslverr,
	// Status in
	input  wire romBridgePkg::romSel_t curSel,
	input  wire [2:0]                led,
	input  wire [`TXN_CNT_W-1:0]     romCount0,
	input  wire [`TXN_CNT_W-1:0]     romCount1,
	input  wire [`TXN_CNT_W-1:0]     romCount2,
	input  wire [`TXN_CNT_W-1:0]     romCount3,
	input  wire [`TXN_CNT_W-1:0]     errCount,
	// Control out
	output logic [`ROM_COUNT-1:0]    enableMask,
	output logic [`HB_PERIOD_W-1:0]  hbPeriod,
	output logic                     periodWrite
);
	import romBridgePkg::*;

	localparam int DataW = `APB_DATA_W;

	regAddr_t           addr;
	logic               access;
	logic               mapped;
	logic               readOnly;
	logic               wrEn;
	logic [DataW-1:0]   readData;

	// --------------------------------------------------
	// Access phase and address decode
	// --------------------------------------------------
	assign access  = iPsel && iPenable;
	assign addr    = regAddr_t'(iPaddr);
	assign oPready = access;              // Zero wait states

	always_comb
	begin
		mapped   = 1'b1;
		readOnly = 1'b1;
		readData = '0;
		case (addr)
			CTRL:
			begin
				readOnly = 1'b0;
				readData = DataW'(enableMask);
			end
			HBPERIOD:
			begin
				readOnly = 1'b0;
				readData = DataW'(hbPeriod);
			end
			STATUS:  readData = DataW'({led, 1'b0, curSel.index, curSel.valid});
			ERRCNT:  readData = DataW'(errCount);
			ROMCNT0: readData = DataW'(romCount0);
			ROMCNT1: readData = DataW'(romCount1);
			ROMCNT2: readData = DataW'(romCount2);
			ROMCNT3: readData = DataW'(romCount3);
			default: mapped   = 1'b0;      // Hole in the map
		endcase
	end

	// Error on unmapped address or write to a status word
	assign oPslverr = access && (!mapped || (iPwrite && readOnly));
	assign oPrdata  = (access && !iPwrite && !oPslverr) ? readData : '0;

	// --------------------------------------------------
	// Write side
	// --------------------------------------------------
	assign wrEn        = access && iPwrite && !oPslverr;
	assign periodWrite = wrEn && (addr == HBPERIOD);   // Also restarts the heartbeat

	always_ff @(posedge iSCLK, negedge iPllLocked)
	begin
		if (!iPllLocked)
		begin
			enableMask <= '1;                    // All ROMs routed
			hbPeriod   <= `HB_PERIOD_W'(`HB_PERIOD_DEFAULT);
		end
		else if (wrEn)
		begin
			if (addr == CTRL)
				enableMask <= iPwdata[`ROM_COUNT-1:0];
			if (periodWrite)
				hbPeriod <= iPwdata[`HB_PERIOD_W-1:0];
		end
	end

endmodule

`default_nettype wire

//--- logic/heartbeat.sv
// LED heartbeat whose step period is set from the APB HBPERIOD register
`timescale 1ns/1ps
`default_nettype none
`include "romBridge_params.svh"

module heartbeat (
	input  wire                     iSCLK,
	input  wire                     iPllLocked,
	input  wire [`HB_PERIOD_W-1:0]  hbPeriod,      // Counter wraps after this value
	input  wire                     periodWrite,   // HBPERIOD write strobe
	output logic [2:0]              led
);

	logic [`HB_PERIOD_W-1:0] count;
	logic                    wrap;

	// --------------------------------------------------
	// Period compare
	// --------------------------------------------------
	assign wrap = (count == hbPeriod);     // One cycle every P+1 clocks

	// --------------------------------------------------
	// Counter and LED step
	// --------------------------------------------------
	always_ff @(posedge iSCLK, negedge iPllLocked)
	begin
		if (!iPllLocked)
		begin
			count <= '0;
			led   <= 3'b000;
		end
		else
		begin
			// New period counts from zero
			if (periodWrite)
				count <= '0;
			else if (wrap)
				count <= '0;
			else
				count <= count + 1'b1;

			// LED advances on the wrap cycle only
			if (wrap)
				led <= led + 3'd1;   // Rolls over 7 -> 0
		end
	end

endmodule

`default_nettype wire

//--- logic/romBridgePkg.sv
// Shared types for the ROM bridge, imported by the router, register block and top level
`default_nettype none

package romBridgePkg;

	// --------------------------------------------------
	// APB register map, byte addresses
	// --------------------------------------------------
	typedef enum logic [7:0] {
		CTRL     = 8'h00,   // Enable mask [3:0]
		HBPERIOD = 8'h04,   // Heartbeat period
		STATUS   = 8'h08,   // Selection and LED, read only
		ERRCNT   = 8'h0C,   // Selection errors, read only
		ROMCNT0  = 8'h10,
		ROMCNT1  = 8'h14,
		ROMCNT2  = 8'h18,
		ROMCNT3  = 8'h1C    // Last of the transaction counters
	} regAddr_t;

	// Router selection as reported to STATUS
	typedef struct packed {
		logic       valid;  // Some ROM has been selected
		logic [1:0] index;  // Last ROM with a clean one-hot select
	} romSel_t;

endpackage

`default_nettype wire

//--- logic/romBridgeTop.sv
// Board top of the ROM bridge FPGA, ties the SPI router, heartbeat and APB registers to the pins
`timescale 1ns/1ps
`default_nettype none
`include "romBridge_params.svh"

module romBridgeTop (
	// Clock and reset
	input  wire                      iSCLK,
	input  wire                      iPllLocked,     // Also the async reset
	// APB configuration port
	input  wire                      iPsel,
	input  wire                      iPenable,
	input  wire                      iPwrite,
	input  wire [`APB_ADDR_W-1:0]    iPaddr,
	input  wire [`APB_DATA_W-1:0]    iPwdata,
	output wire [`APB_DATA_W-1:0]    oPrdata,
	output wire                      oPready,
	output wire                      oPslverr,
	// Shared SPI master
	input  wire                      iMaster_MOSI,
	input  wire                      iMaster_SCK,
	input  wire [`ROM_COUNT-1:0]     iMaster_nCS,
	output wire                      oMaster_MISO,
	// User ROMs
	input  wire [`ROM_COUNT-1:0]     iUser_MISO,
	output wire [`ROM_COUNT-1:0]     oUser_MOSI,
	output wire [`ROM_COUNT-1:0]     oUser_SCK,
	output wire [`ROM_COUNT-1:0]     oUser_nCS,
	// Board
	output wire [3:0]                oUserDebug,
	output wire [2:0]                oLed
);
	import romBridgePkg::*;

	romSel_t                 curSel;
	logic [`TXN_CNT_W-1:0]   romCount0;
	logic [`TXN_CNT_W-1:0]   romCount1;
	logic [`TXN_CNT_W-1:0]   romCount2;
	logic [`TXN_CNT_W-1:0]   romCount3;
	logic [`TXN_CNT_W-1:0]   errCount;
	logic [`ROM_COUNT-1:0]   enableMask;
	logic [`HB_PERIOD_W-1:0] hbPeriod;
	logic                    periodWrite;

	// --------------------------------------------------
	// SPI router
	// --------------------------------------------------
	spiRouter spiRouter_i (
		.iSCLK(iSCLK), .iPllLocked(iPllLocked),
		.iMaster_MOSI(iMaster_MOSI), .iMaster_SCK(iMaster_SCK),
		.iMaster_nCS(iMaster_nCS), .oMaster_MISO(oMaster_MISO),
		.iUser_MISO(iUser_MISO), .oUser_MOSI(oUser_MOSI),
		.oUser_SCK(oUser_SCK), .oUser_nCS(oUser_nCS),
		.oUserDebug(oUserDebug), .enableMask(enableMask), .curSel(curSel),
		.romCount0(romCount0), .romCount1(romCount1),
		.romCount2(romCount2), .romCount3(romCount3), .errCount(errCount)
	);

	// LED heartbeat, also read back through STATUS
	heartbeat heartbeat_i (
		.iSCLK(iSCLK), .iPllLocked(iPllLocked),
		.hbPeriod(hbPeriod), .periodWrite(periodWrite), .led(oLed)
	);

	// --------------------------------------------------
	// APB registers
	// --------------------------------------------------
	apbRegs apbRegs_i (
		.iSCLK(iSCLK), .iPllLocked(iPllLocked),
		.iPsel(iPsel), .iPenable(iPenable), .iPwrite(iPwrite),
		.iPaddr(iPaddr), .iPwdata(iPwdata),
		.oPrdata(oPrdata), .oPready(oPready), .oPslverr(oPslverr),
		.curSel(curSel), .led(oLed),
		.romCount0(romCount0), .romCount1(romCount1),
		.romCount2(romCount2), .romCount3(romCount3), .errCount(errCount),
		.enableMask(enableMask), .hbPeriod(hbPeriod), .periodWrite(periodWrite)
	);

endmodule

`default_nettype wire

//--- logic/romBridge_params.svh
// Build-time sizes for the ROM bridge, included by every RTL file that needs a width or default
`ifndef ROMBRIDGE_PARAMS_SVH
`define ROMBRIDGE_PARAMS_SVH

// --------------------------------------------------
// SPI side
// --------------------------------------------------
`define ROM_COUNT 4             // User flash ROMs behind the shared master
`define TXN_CNT_W 16            // Per-ROM and error counter width

// --------------------------------------------------
// LED heartbeat
// --------------------------------------------------
`define HB_PERIOD_W 26          // Enough for 50 MHz / ~2.5 Hz
`define HB_PERIOD_DEFAULT 19999999

// --------------------------------------------------
// APB register port
// --------------------------------------------------
`define APB_ADDR_W 8            // Byte address, word aligned
`define APB_DATA_W 32

`endif

//--- logic/spiRouter.sv
// Routes the shared SPI master to the user ROMs and counts transactions and selection errors
`timescale 1ns/1ps
`default_nettype none
`include "romBridge_params.svh"

module spiRouter (
	input  wire                   iSCLK,
	input  wire                   iPllLocked,
	// Master side
	input  wire                   iMaster_MOSI,
	input  wire                   iMaster_SCK,
	input  wire [`ROM_COUNT-1:0]  iMaster_nCS,
	output logic                  oMaster_MISO,
	// ROM side
	input  wire [`ROM_COUNT-1:0]  iUser_MISO,
	output logic [`ROM_COUNT-1:0] oUser_MOSI,
	output logic [`ROM_COUNT-1:0] oUser_SCK,
	output logic [`ROM_COUNT-1:0] oUser_nCS,
	output logic [3:0]            oUserDebug,   // {&nCS, SCK, MOSI, MISO}
	// Control and status
	input  wire [`ROM_COUNT-1:0]  enableMask,
	output romBridgePkg::romSel_t curSel,
	output logic [`TXN_CNT_W-1:0] romCount0,
	output logic [`TXN_CNT_W-1:0] romCount1,
	output logic [`TXN_CNT_W-1:0] romCount2,
	output logic [`TXN_CNT_W-1:0] romCount3,
	output logic [`TXN_CNT_W-1:0] errCount
);
	import romBridgePkg::*;

	logic [`ROM_COUNT-1:0] gatedNcs;        // Master selects with disabled ROMs forced high
	logic [`ROM_COUNT-1:0] csReg;           // Stage 1, gated
	logic [`ROM_COUNT-1:0] masterReg;       // Stage 1, raw master
	logic [`ROM_COUNT-1:0] masterPrev;      // Stage 2, raw master
	logic [2:0]            lowCount;
	logic [1:0]            selIndex;
	logic                  selValid;
	logic [1:0]            prevIndex;
	logic                  prevValid;
	logic                  txnEvent;
	logic                  errEvent;
	logic [`TXN_CNT_W-1:0] romCnt [`ROM_COUNT];
	romSel_t               lastSel;

	// --------------------------------------------------
	// Pass-through and chip-select gating
	// --------------------------------------------------
	assign oUser_MOSI = {`ROM_COUNT{iMaster_MOSI}};
	assign oUser_SCK  = {`ROM_COUNT{iMaster_SCK}};
	assign gatedNcs   = iMaster_nCS | ~enableMask;
	assign oUser_nCS  = gatedNcs;

	// Selection decode from the registered selects
	always_comb
	begin
		lowCount = '0;
		selIndex = '0;
		for (int k = 0; k < `ROM_COUNT; k++)
		begin
			if (!csReg[k])
			begin
				lowCount = lowCount + 3'd1;
				selIndex = 2'(k);       // Only meaningful when exactly one is low
			end
		end
		selValid = (lowCount == 3'd1);
	end

	// MISO back from the one selected ROM, else 0
	assign oMaster_MISO = selValid ? iUser_MISO[selIndex] : 1'b0;

	// --------------------------------------------------
	// Two register stages for edge detection
	// --------------------------------------------------
	always_ff @(posedge iSCLK, negedge iPllLocked)
	begin
		if (!iPllLocked)
		begin
			csReg      <= '1;           // All deselected
			masterReg  <= '1;
			masterPrev <= '1;
			prevValid  <= 1'b0;
			prevIndex  <= '0;
			lastSel    <= '0;
		end
		else
		begin
			csReg      <= gatedNcs;
			masterReg  <= iMaster_nCS;
			masterPrev <= masterReg;
			prevValid  <= selValid;
			prevIndex  <= selIndex;
			if (selValid)
				lastSel <= '{valid: 1'b1, index: selIndex};   // Sticky for STATUS
		end
	end

	// New valid selection, also a direct hop between ROMs
	assign txnEvent = selValid && (!prevValid || prevIndex != selIndex);
	// Master asked for something the gating did not turn into one ROM
	assign errEvent = |(masterPrev & ~masterReg) && !selValid;

	// --------------------------------------------------
	// Saturating counters
	// --------------------------------------------------
	always_ff @(posedge iSCLK, negedge iPllLocked)
	begin
		if (!iPllLocked)
		begin
			for (int k = 0; k < `ROM_COUNT; k++)
				romCnt[k] <= '0;
			errCount <= '0;
		end
		else
		begin
			if (txnEvent && romCnt[selIndex] != '1)
				romCnt[selIndex] <= romCnt[selIndex] + 1'b1;
			if (errEvent && errCount != '1)
				errCount <= errCount + 1'b1;
		end
	end

	assign romCount0 = romCnt[0];
	assign romCount1 = romCnt[1];
	assign romCount2 = romCnt[2];
	assign romCount3 = romCnt[3];
	assign curSel    = lastSel;

	// Debug pins, one cycle behind the master lines
	always_ff @(posedge iSCLK)
	begin
		oUserDebug <= {&iMaster_nCS, iMaster_SCK, iMaster_MOSI, oMaster_MISO};
	end

endmodule

`default_nettype wire

//--- romBridge.f
+incdir+logic
logic/romBridgePkg.sv
logic/spiRouter.sv
logic/heartbeat.sv
logic/apbRegs.sv
logic/romBridgeTop.sv
dv/tbClock.sv
dv/romBridgeTb.sv
